/* Bender.yml */
package:
  name: occupancy_threshold

sources:
  # configuration and types come first, the counters import them
  - verilog/occ_cfg_pkg.sv
  - verilog/occ_types_pkg.sv
  - verilog/occ_lo_counter.sv
  - verilog/occ_upper_counter.sv
  - verilog/threshold_decide.sv
  - verilog/occupancy_threshold.sv

  - target: test
    files:
      - verification/occupancy_threshold_tb.sv

/* verification/occupancy_threshold_tb.sv */
// testbench for the occupancy threshold tracker
// steps are driven on falling edges and only legal steps are generated
// the reference occupancy is updated on rising edges like the DUT
// concurrent assertions compare threshold_reached with the reference every clock
`timescale 1ns/100ps

module occupancy_threshold_tb
    import occ_cfg_pkg::*;
    import occ_types_pkg::*;
();

    ////////////////////////////////////////
    // run length
    ////////////////////////////////////////

    localparam int RESET_CYCLES = 16;
    localparam int WINDOW       = 40;
    localparam int NEAR_CYCLES  = 4000;
    localparam int EDGE_SPAN    = 24;
    localparam int EDGE_CYCLES  = 800;
    localparam int BOUNCES      = 16;

    // four full sweeps cover both ramps and the moves between phases
    localparam int MAX_CYCLES = RESET_CYCLES + 4 * CAPACITY + THRESHOLD + NEAR_CYCLES +
                                2 * EDGE_CYCLES + 8 * BOUNCES + 500;

    logic      clock = 1'b1;
    logic      aclrn;
    occ_step_t step;
    logic      threshold_reached;

    // reference occupancy after the last sampled step
    int occ = INITIAL_OCCUPANCY;

    int   seed = 32'h1214;
    int   cycle_count = 0;
    int   mismatch_count = 0;
    int   fault_count = 0;

    always #50 clock = ~clock;

    occupancy_threshold dut_i (
        .clock             (clock),
        .aclrn             (aclrn),
        .step              (step),
        .threshold_reached (threshold_reached)
    );

    // a single incr or decr moves the reference by one, anything else holds it
    always @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            occ <= INITIAL_OCCUPANCY;
        end
        else if (step.incr && !step.decr) begin
            occ <= occ + 1;
        end
        else if (!step.incr && step.decr) begin
            occ <= occ - 1;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // the output must be low throughout reset
    reset_low_a: assert property (
        @(posedge clock)
        !aclrn |-> !threshold_reached
    ) else begin
        mismatch_count++;
        $display("mismatch at %0t: threshold_reached is high during reset", $time);
    end

    // one clock after each step the output equals the reference comparison
    reached_matches_a: assert property (
        @(posedge clock) disable iff (!aclrn)
        threshold_reached == (occ >= THRESHOLD)
    ) else begin
        mismatch_count++;
        $display("mismatch at %0t: threshold_reached %0b, expected %0b at occupancy %0d",
                 $time, $sampled(threshold_reached), $sampled(occ) >= THRESHOLD,
                 $sampled(occ));
    end

    // incr and decr together, or neither, must leave the output alone
    hold_keeps_output_a: assert property (
        @(posedge clock) disable iff (!aclrn)
        (step.incr == step.decr) |=> $stable(threshold_reached)
    ) else begin
        mismatch_count++;
        $display("mismatch at %0t: threshold_reached moved on a cycle without a step",
                 $time);
    end

    // the stimulus itself must stay within the legal range
    no_incr_at_full_a: assert property (
        @(posedge clock) disable iff (!aclrn)
        !(step.incr && !step.decr && occ >= CAPACITY)
    ) else begin
        fault_count++;
        $display("stimulus error: an increment was driven while the FIFO was full");
    end

    no_decr_at_empty_a: assert property (
        @(posedge clock) disable iff (!aclrn)
        !(!step.incr && step.decr && occ <= 0)
    ) else begin
        fault_count++;
        $display("stimulus error: a decrement was driven while the FIFO was empty");
    end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    // called on a falling edge, returns on the next one
    task automatic drive_step(input logic incr, input logic decr);
        step.incr = incr;
        step.decr = decr;
        @(negedge clock);
    endtask

    // a write with a read, then an idle cycle
    task automatic hold_pair();
        drive_step(1'b1, 1'b1);
        drive_step(1'b0, 1'b0);
    endtask

    // full sweep in one direction, pausing on both sides of the threshold
    task automatic ramp(input logic up);
        for (int i = 0; i < CAPACITY; i++) begin
            if (occ == THRESHOLD - 1 || occ == THRESHOLD) begin
                hold_pair();
            end
            drive_step(up, !up);
        end
    endtask

    task automatic move_to(input int target);
        while (occ != target) begin
            drive_step(occ < target, occ > target);
        end
    endtask

    // random steps, turned around at the window edges so they stay legal
    task automatic random_walk(input int low, input int high, input int cycles);
        int   r;
        logic incr;
        logic decr;
        for (int i = 0; i < cycles; i++) begin
            r    = $random(seed);
            incr = r[0];
            decr = r[1];
            if (incr && !decr && occ >= high) begin
                incr = 1'b0;
                decr = 1'b1;
            end
            else if (!incr && decr && occ <= low) begin
                incr = 1'b1;
                decr = 1'b0;
            end
            drive_step(incr, decr);
        end
    endtask

    // back to back reversals, starting away from the edge the walk sits on
    task automatic bounce(input logic up_first, input int count);
        for (int i = 0; i < count; i++) begin
            drive_step(up_first, !up_first);
            drive_step(!up_first, up_first);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        aclrn = 1'b1;
        step  = '0;

        @(negedge clock);
        aclrn = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        aclrn = 1'b1;

        repeat (4) drive_step(1'b0, 1'b0);

        // sweeps pass through every mid and high wrap in both directions
        ramp(1'b1);
        hold_pair();
        ramp(1'b0);

        // long walk around the threshold with frequent turns
        move_to(THRESHOLD - WINDOW / 2);
        random_walk(THRESHOLD - WINDOW, THRESHOLD + WINDOW, NEAR_CYCLES);

        // walks and reversals at the empty end
        move_to(0);
        bounce(1'b1, BOUNCES);
        random_walk(0, EDGE_SPAN, EDGE_CYCLES);
        move_to(0);
        bounce(1'b1, BOUNCES);

        // and at the full end
        move_to(CAPACITY);
        bounce(1'b0, BOUNCES);
        random_walk(CAPACITY - EDGE_SPAN, CAPACITY, EDGE_CYCLES);
        move_to(CAPACITY);
        bounce(1'b0, BOUNCES);

        // let the last step reach the comparison
        repeat (3) drive_step(1'b0, 1'b0);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("TEST OK");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog/occ_cfg_pkg.sv */
// fixed configuration of the occupancy threshold tracker
// the occupancy must stay within 0 to CAPACITY and move by at most one per clock
// THRESHOLD must lie strictly above INITIAL_OCCUPANCY and at or below CAPACITY
// only the general mid-range case is supported, so THRESHOLD must also stay away from 1 and CAPACITY

package occ_cfg_pkg;

    ////////////////////////////////////////
    // user configuration
    ////////////////////////////////////////

    // highest occupancy the FIFO can ever hold
    localparam int CAPACITY = 1024;

    // threshold_reached is high while occupancy is at or above this level
    localparam int THRESHOLD = 700;

    // occupancy right after reset
    localparam int INITIAL_OCCUPANCY = 0;

    ////////////////////////////////////////
    // derived sizes
    ////////////////////////////////////////

    // the counter really tracks distance to the threshold, so only this difference matters
    localparam int INIT_OCC_TO_THRESH = THRESHOLD - INITIAL_OCCUPANCY;

    // bits 1:0 are exact and bits 4:2 are one clock late
    // everything from bit 5 upwards is the tessellated high part
    localparam int HI_BITS = $clog2(CAPACITY) - 5;

    // each tessellation stage holds at least this many high bits
    // smaller stages would add wrap registers without helping timing
    localparam int MIN_TESS_SIZE = 4;

    // ceiling of HI_BITS over MIN_TESS_SIZE
    // each stage adds one clock of lateness, two stages keep it well inside the budget
    localparam int TESS_STAGES = (HI_BITS + MIN_TESS_SIZE - 1) / MIN_TESS_SIZE;

    ////////////////////////////////////////
    // reset values
    ////////////////////////////////////////

    // the counter is built so that a distance of 0 to the threshold sits at lo=2, mid=1, hi=0
    // lo is offset by 2 and counts the usual way
    // mid and hi count in reverse, the group of 8 for mid is offset by 5
    // and the group of 32 for hi is offset by 13, which leaves the slack for stale bits
    // shifting the distance to the threshold just moves that many columns along the pattern
    localparam logic [1:0] LO_RESET = 2'(2 - INIT_OCC_TO_THRESH);

    // bits 4:2 of five plus the distance
    localparam logic [2:0] MID_RESET = 3'((5 + INIT_OCC_TO_THRESH) >> 2);

    // bits HI_BITS+4:5 of thirteen plus the distance
    localparam logic [HI_BITS-1:0] HI_RESET = HI_BITS'((13 + INIT_OCC_TO_THRESH) >> 5);

endpackage

/* verilog/occ_lo_counter.sv */
// exact counter for occupancy bits 1:0
// follows the step on the same edge, there is no back-pressure
// lo_wrap tells the stale upper counter that a carry or borrow left bit 1
`timescale 1ns/100ps

module occ_lo_counter
    import occ_cfg_pkg::*;
    import occ_types_pkg::*;
(
    input  logic      clock,
    input  logic      aclrn,
    input  occ_step_t step,
    output lo_state_t lo_state
);

    lo_t  lo;
    logic lo_wrap;
    logic step_up;
    logic step_down;

    // a step only moves the count when exactly one of incr and decr is high
    assign step_up   = step.incr & ~step.decr;
    assign step_down = ~step.incr & step.decr;

    ////////////////////////////////////////
    // low count and wrap detect
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            lo      <= LO_RESET;
            lo_wrap <= 1'b0;
        end
        else begin
            // bit 0 toggles whenever exactly one of incr and decr is set
            lo[0] <= lo[0] ^ step.incr ^ step.decr;

            // bit 1 toggles on a carry out of bit 0 going up
            // or on a borrow out of bit 0 going down
            lo[1] <= lo[1] ^ (step_up & lo[0]) ^ (step_down & ~lo[0]);

            // next-state test, so the registered pulse lines up with the actual wrap
            // 3 and going up or 0 and going down
            lo_wrap <= (step_up & (lo == 2'd3)) | (step_down & (lo == 2'd0));
        end
    end

    assign lo_state.lo      = lo;
    assign lo_state.lo_wrap = lo_wrap;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // a wrap pulse always comes with a single move across the 3 to 0 boundary
    // the upper counter takes its direction from lo parity, so this must hold
    lo_wrap_single_step_a: assert property (
        @(posedge clock) disable iff (!aclrn)
        lo_wrap |-> ((lo == 2'd0) && ($past(lo) == 2'd3)) ||
                    ((lo == 2'd3) && ($past(lo) == 2'd0))
    ) else $error("lo_wrap without a single step between 3 and 0");

endmodule

/* verilog/occ_types_pkg.sv */
// data types shared by the occupancy threshold tracker
// the high count width follows HI_BITS from the configuration package

package occ_types_pkg;

    import occ_cfg_pkg::*;

    ////////////////////////////////////////
    // counter fields
    ////////////////////////////////////////

    // exact low two bits of the occupancy
    typedef logic [1:0] lo_t;

    // occupancy bits 4:2, stored in reverse counting order
    typedef logic [2:0] mid_t;

    // occupancy bits from 5 upwards, also stored in reverse counting order
    typedef logic [HI_BITS-1:0] hi_t;

    ////////////////////////////////////////
    // interfaces between blocks
    ////////////////////////////////////////

    // one occupancy step per clock
    // incr must be low at CAPACITY and decr must be low at 0
    // both high together means a write and a read that cancel out
    typedef struct packed {
        logic incr;
        logic decr;
    } occ_step_t;

    // state of the exact low counter as seen by the later stages
    // lo_wrap pulses for one clock on the edge where lo moved between 3 and 0
    typedef struct packed {
        lo_t  lo;
        logic lo_wrap;
    } lo_state_t;

endpackage

/* verilog/occ_upper_counter.sv */
// stale counter for occupancy bits 4:2 and all higher bits
// mid and the high stages count in reverse order relative to the occupancy
// the zero detect and count_at_target have no reset, hold aclrn for at least 4 clocks
// later high wrap registers also settle only through held reset
// relies on the occupancy moving by at most one per clock
`timescale 1ns/100ps

module occ_upper_counter
    import occ_cfg_pkg::*;
    import occ_types_pkg::*;
(
    input  logic      clock,
    input  logic      aclrn,
    input  lo_state_t lo_state,
    output logic      count_at_target
);

    mid_t mid;
    logic mid_wrap;
    hi_t  hi;

    // index 0 describes mid, index g+1 describes high stage g
    logic [TESS_STAGES:0] wrap;
    logic [TESS_STAGES:0] odd;

    // stale check that {hi, mid[2]} is all zero
    logic upper_zeros;

    ////////////////////////////////////////
    // mid count, one clock late
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            mid      <= MID_RESET;
            mid_wrap <= 1'b0;
        end
        else begin
            if (lo_state.lo_wrap) begin
                // lo odd right after a wrap means it went from 0 to 3
                // the occupancy went down, so the reversed mid count goes up
                if (lo_state.lo[0]) begin
                    mid <= mid + 1'b1;
                end
                else begin
                    mid <= mid - 1'b1;
                end
            end

            // mid wraps between 5 and 6 rather than 7 and 0
            // that keeps the group of 4 aligned with the high groups
            mid_wrap <= lo_state.lo_wrap &
                        (lo_state.lo[0] ? (mid == 3'd5) : (mid == 3'd6));
        end
    end

    // the first high stage takes its enable and direction from mid
    assign wrap[0] = mid_wrap;
    assign odd[0]  = mid[0];

    ////////////////////////////////////////
    // tessellated high stages
    ////////////////////////////////////////

    for (genvar g = 0; g < TESS_STAGES; g++) begin : gen_hi_stage
        // bit range of hi owned by this stage, START inclusive and STOP exclusive
        localparam int START = g * HI_BITS / TESS_STAGES;
        localparam int STOP  = (g + 1) * HI_BITS / TESS_STAGES;

        logic [STOP-START-1:0] seg;
        logic                  seg_wrap;
        logic                  seg_wrap_next;

        // wrap when going down from 0 or going up from all ones
        assign seg_wrap_next = wrap[g] & (odd[g] ? ~(|seg) : (&seg));

        always_ff @(posedge clock or negedge aclrn) begin
            if (!aclrn) begin
                seg <= HI_RESET[STOP-1:START];
            end
            else if (wrap[g]) begin
                // odd previous stage means the occupancy went up, so the reversed count goes down
                if (odd[g]) begin
                    seg <= seg - 1'b1;
                end
                else begin
                    seg <= seg + 1'b1;
                end
            end
        end

        if (g == 0) begin : gen_wrap_rst
            // the first high wrap is cleared directly
            always_ff @(posedge clock or negedge aclrn) begin
                if (!aclrn) begin
                    seg_wrap <= 1'b0;
                end
                else begin
                    seg_wrap <= seg_wrap_next;
                end
            end
        end
        else begin : gen_wrap_free
            // previous wrap is held low in reset, so this one clears a clock later
            always_ff @(posedge clock) begin
                seg_wrap <= seg_wrap_next;
            end
        end

        assign hi[STOP-1:START] = seg;
        assign wrap[g+1]        = seg_wrap;
        assign odd[g+1]         = seg[0];

        // a stage can only wrap on the clock after the stage below it wrapped
        // and the parity it hands on must keep the direction of that carry or borrow
        hi_wrap_chain_a: assert property (
            @(posedge clock) disable iff (!aclrn)
            wrap[g+1] |-> $past(wrap[g]) && (odd[g+1] == $past(odd[g]))
        ) else $error("high stage %0d wrapped without a matching carry from below", g);
    end

    ////////////////////////////////////////
    // target detect
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        // mid[2] is slow enough to be judged together with the high bits
        upper_zeros <= ({hi, mid[2]} == '0);

        // mid[1:0] next state equals 1 when it is 1 and idle,
        // or 0 and about to count up, or 2 and about to count down
        count_at_target <= upper_zeros &
                           (!lo_state.lo_wrap ? (mid[1:0] == 2'd1) :
                            lo_state.lo[0]    ? (mid[1:0] == 2'd0) :
                                                (mid[1:0] == 2'd2));
    end

endmodule

/* verilog/occupancy_threshold.sv */
// occupancy threshold tracker, top level
// threshold_reached reflects the step sampled on the previous edge
// every step is consumed on the edge that samples it, there is no back-pressure
// hold aclrn low for at least 4 clocks so the unreset pipeline settles
`timescale 1ns/100ps

module occupancy_threshold
    import occ_types_pkg::*;
(
    input  logic      clock,
    input  logic      aclrn,
    input  occ_step_t step,
    output logic      threshold_reached
);

    lo_state_t lo_state;
    logic      count_at_target;

    // exact bits 1:0 and the wrap pulse for the upper part
    occ_lo_counter lo_counter_i (
        .clock    (clock),
        .aclrn    (aclrn),
        .step     (step),
        .lo_state (lo_state)
    );

    // stale bits 4:2 and above, reduced to one at-target flag
    occ_upper_counter upper_counter_i (
        .clock           (clock),
        .aclrn           (aclrn),
        .lo_state        (lo_state),
        .count_at_target (count_at_target)
    );

    // combine the exact low count with the stale flag
    threshold_decide decide_i (
        .clock             (clock),
        .aclrn             (aclrn),
        .step              (step),
        .lo_state          (lo_state),
        .count_at_target   (count_at_target),
        .threshold_reached (threshold_reached)
    );

endmodule

/* verilog/threshold_decide.sv */
// final stage that flips threshold_reached at the crossing point
// the crossing is decided from exact lo and the stale count_at_target
// threshold_reached resets low, THRESHOLD is above the initial occupancy
`timescale 1ns/100ps

module threshold_decide
    import occ_types_pkg::*;
(
    input  logic      clock,
    input  logic      aclrn,
    input  occ_step_t step,
    input  lo_state_t lo_state,
    input  logic      count_at_target,
    output logic      threshold_reached
);

    logic step_up;
    logic step_down;

    // incr and decr together cancel and never move the output
    assign step_up   = step.incr & ~step.decr;
    assign step_down = ~step.incr & step.decr;

    ////////////////////////////////////////
    // crossing decision
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            threshold_reached <= 1'b0;
        end
        else begin
            // lo=1 with the upper bits on target is one below the threshold
            // so a pure increment lands exactly on it
            if (step_up & (lo_state.lo == 2'd1) & count_at_target) begin
                threshold_reached <= 1'b1;
            end
            // lo=2 with the upper bits on target is the threshold itself
            // and a pure decrement drops below it
            else if (step_down & (lo_state.lo == 2'd2) & count_at_target) begin
                threshold_reached <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // the output only moves on a real step, and that step crosses between lo 1 and 2
    // so the low counter can never report a wrap on the same edge
    reached_moves_on_step_a: assert property (
        @(posedge clock) disable iff (!aclrn)
        $changed(threshold_reached) |->
            $past(step.incr ^ step.decr) && !lo_state.lo_wrap
    ) else $error("threshold_reached changed without a single step");

endmodule

/* vlog.f */
verilog/occ_cfg_pkg.sv
verilog/occ_types_pkg.sv
verilog/occ_lo_counter.sv
verilog/occ_upper_counter.sv
verilog/threshold_decide.sv
verilog/occupancy_threshold.sv
verification/occupancy_threshold_tb.sv
